//--- Makefile
TOP := tb_ls_top
RTL_TOP := ls_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(RTL_TOP)
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- hw/dmem_wb.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_wb import mem_bus_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire wb_m2s_t       wb_m_i,
    output wb_s2m_t            wb_s_o
);

    logic [WB_DW-1:0]   mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic               first;
    logic               ack_q;
    logic [WB_DW-1:0]   rdata_q;

    // doubleword index, upper bits wrap
    assign idx = wb_m_i.adr[DMEM_AW+WB_OB-1:WB_OB];

    // strobe seen, ack not yet given
    assign first = wb_m_i.cyc && wb_m_i.stb && !ack_q;

    // ack one cycle after stb, then drop
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= first;
        end
    end

    // byte-select write
    always_ff @(posedge clk) begin
        if (first && wb_m_i.we) begin
            for (int b = 0; b < WB_SW; b++) begin
                if (wb_m_i.sel[b]) begin
                    mem[idx][b*8 +: 8] <= wb_m_i.dat[b*8 +: 8];
                end
            end
        end
    end

    // full doubleword read, lined up with ack
    always_ff @(posedge clk) begin
        if (first && !wb_m_i.we) begin
            rdata_q <= mem[idx];
        end
    end

    assign wb_s_o.ack = ack_q;
    assign wb_s_o.dat = rdata_q;

endmodule

`default_nettype wire

//--- hw/load_align.sv
`timescale 1ns/10ps
`default_nettype none

module load_align import rv_isa_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire ls_acc_t       acc_i,
    output logic               res_valid_o,
    output logic [REG_AW-1:0]  res_rd_o,
    output logic [XLEN-1:0]    res_data_o
);

    logic [XLEN-1:0]   shifted;
    logic [XLEN-1:0]   ext;
    logic              res_valid_q;
    logic [REG_AW-1:0] res_rd_q;
    logic [XLEN-1:0]   res_data_q;

    // addressed lanes down to bit 0
    assign shifted = acc_i.data >> {acc_i.off, 3'b000};

    // extend by size and signedness
    always_comb begin
        case (acc_i.funct3)
            F3_LB:   ext = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            F3_LBU:  ext = {{(XLEN-8){1'b0}}, shifted[7:0]};
            F3_LH:   ext = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            F3_LHU:  ext = {{(XLEN-16){1'b0}}, shifted[15:0]};
            F3_LW:   ext = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            F3_LWU:  ext = {{(XLEN-32){1'b0}}, shifted[31:0]};
            // ld, whole doubleword as is
            F3_LD:   ext = acc_i.data;
            default: ext = acc_i.data;
        endcase
    end

    // result pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= acc_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_i.valid) begin
            res_rd_q   <= acc_i.rd;
            res_data_q <= ext;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_rd_o    = res_rd_q;
    assign res_data_o  = res_data_q;

endmodule

`default_nettype wire

//--- hw/ls_access.sv
`timescale 1ns/10ps
`default_nettype none

module ls_access import rv_isa_pkg::*, mem_bus_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                dec_valid_i,
    input  wire ls_req_t       dec_req_i,
    input  wire wb_s2m_t       wb_s_i,
    output logic               acc_ready_o,
    output wb_m2s_t            wb_m_o,
    output ls_acc_t            acc_o
);

    logic             busy_q;
    ls_req_t          req_q;
    ls_req_t          cur;
    logic             cyc;
    logic             done;
    logic [WB_SW-1:0] sel_base;
    ls_acc_t          acc_q;

    // first cycle runs straight off the decode register
    // then off the local copy until ack
    assign cur  = busy_q ? req_q : dec_req_i;
    assign cyc  = busy_q || dec_valid_i;
    assign done = cyc && wb_s_i.ack;

    // ready only with no cycle open
    assign acc_ready_o = !busy_q;

    // lane mask before the offset shift
    always_comb begin
        case (cur.funct3[1:0])
            F3_LB[1:0]: sel_base = 8'h01;
            F3_LH[1:0]: sel_base = 8'h03;
            F3_LW[1:0]: sel_base = 8'h0f;
            default:    sel_base = 8'hff;
        endcase
    end

    always_comb begin
        wb_m_o.cyc = cyc;
        wb_m_o.stb = cyc;
        wb_m_o.we  = cur.is_store;
        // misaligned shifts lanes off the top and leaves them undefined
        wb_m_o.sel = sel_base << cur.addr[WB_OB-1:0];
        // doubleword aligned address
        wb_m_o.adr = {cur.addr[WB_AW-1:WB_OB], {WB_OB{1'b0}}};
        // store data moved onto its byte lanes
        wb_m_o.dat = cur.wdata << {cur.addr[WB_OB-1:0], 3'b000};
    end

    // cycle open flag
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= cyc && !wb_s_i.ack;
        end
    end

    // hold request while the cycle is open
    always_ff @(posedge clk) begin
        if (!busy_q && dec_valid_i) begin
            req_q <= dec_req_i;
        end
    end

    // load return valid for one cycle
    // stores end silently
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q.valid <= done && cur.is_load;
            if (done) begin
                acc_q.funct3 <= cur.funct3;
                acc_q.rd     <= cur.rd;
                acc_q.off    <= cur.addr[2:0];
                acc_q.data   <= wb_s_i.dat;
            end
        end
    end

    assign acc_o = acc_q;

endmodule

`default_nettype wire

//--- hw/ls_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ls_decode import rv_isa_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                req_valid_i,
    input  wire instr_u        req_instr_i,
    input  wire [XLEN-1:0]     req_rs1_i,
    input  wire [XLEN-1:0]     req_rs2_i,
    input  wire                fwd_valid_i,
    input  wire [REG_AW-1:0]   fwd_rd_i,
    input  wire [XLEN-1:0]     fwd_data_i,
    input  wire                acc_ready_i,
    output logic               req_ready_o,
    output logic               dec_valid_o,
    output ls_req_t            dec_req_o
);

    logic              is_load;
    logic              is_store;
    logic [XLEN-1:0]   imm;
    logic              accept;
    logic              handoff;
    logic              hazard;
    logic              fwd_hit;
    logic              dec_valid_q;
    logic              wait_q;
    logic              ld_pend_q;
    logic [REG_AW-1:0] ld_rd_q;
    logic [LDQ_CW-1:0] ld_cnt_q;
    ls_req_t           req_q;

    // opcode picks the view
    assign is_load  = (req_instr_i.i_fmt.opcode == OPC_LOAD);
    assign is_store = (req_instr_i.s_fmt.opcode == OPC_STORE);

    // sign-extended offset from the s view for stores
    always_comb begin
        if (is_store) begin
            imm = {{(XLEN-12){req_instr_i.s_fmt.imm_hi[6]}},
                   req_instr_i.s_fmt.imm_hi, req_instr_i.s_fmt.imm_lo};
        end else begin
            imm = {{(XLEN-12){req_instr_i.i_fmt.imm[11]}}, req_instr_i.i_fmt.imm};
        end
    end

    // newest load returns when it is the only one left
    assign fwd_hit = fwd_valid_i && ld_pend_q && (fwd_rd_i == ld_rd_q) && (ld_cnt_q == 1);
    // store reads the reg the newest load writes
    assign hazard  = is_store && ld_pend_q && (req_instr_i.s_fmt.rs2 == ld_rd_q);

    // waiting store stays invisible downstream
    assign dec_valid_o = dec_valid_q && !wait_q;
    assign dec_req_o   = req_q;
    assign handoff     = dec_valid_o && acc_ready_i;
    assign req_ready_o = !dec_valid_q || handoff;
    assign accept      = req_valid_i && req_ready_o;

    // stage valid and forwarding wait
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
            wait_q      <= 1'b0;
        end else if (accept && (is_load || is_store)) begin
            dec_valid_q <= 1'b1;
            // result already on the bus this cycle means no wait
            wait_q      <= hazard && !fwd_hit;
        end else begin
            if (handoff) begin
                dec_valid_q <= 1'b0;
            end
            if (fwd_hit) begin
                wait_q <= 1'b0;
            end
        end
    end

    // newest load record and count of loads in flight
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ld_pend_q <= 1'b0;
            ld_rd_q   <= '0;
            ld_cnt_q  <= '0;
        end else begin
            if (accept && is_load) begin
                // x0 never forwards
                ld_pend_q <= (req_instr_i.i_fmt.rd != '0);
                ld_rd_q   <= req_instr_i.i_fmt.rd;
            end else if (fwd_hit) begin
                ld_pend_q <= 1'b0;
            end
            case ({accept && is_load, fwd_valid_i})
                2'b10:   ld_cnt_q <= ld_cnt_q + LDQ_CW'(1);
                2'b01:   ld_cnt_q <= ld_cnt_q - LDQ_CW'(1);
                default: ld_cnt_q <= ld_cnt_q;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept && (is_load || is_store)) begin
            req_q.is_load  <= is_load;
            req_q.is_store <= is_store;
            req_q.funct3   <= req_instr_i.i_fmt.funct3;
            req_q.rd       <= req_instr_i.i_fmt.rd;
            req_q.addr     <= req_rs1_i + imm;
            req_q.wdata    <= (hazard && fwd_hit) ? fwd_data_i : req_rs2_i;
        end else if (wait_q && fwd_hit) begin
            // swap in the loaded value for rs2
            req_q.wdata <= fwd_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/ls_top.sv
`timescale 1ns/10ps
`default_nettype none

module ls_top import rv_isa_pkg::*, mem_bus_pkg::*; (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                req_valid_i,
    input  wire instr_u        req_instr_i,
    input  wire [XLEN-1:0]     req_rs1_i,
    input  wire [XLEN-1:0]     req_rs2_i,
    output logic               req_ready_o,
    output logic               res_valid_o,
    output logic [REG_AW-1:0]  res_rd_o,
    output logic [XLEN-1:0]    res_data_o
);

    logic    dec_valid;
    ls_req_t dec_req;
    logic    acc_ready;
    ls_acc_t acc;
    wb_m2s_t wb_m;
    wb_s2m_t wb_s;

    // result pulse doubles as the forwarding path
    ls_decode u_ls_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_instr_i (req_instr_i),
        .req_rs1_i   (req_rs1_i),
        .req_rs2_i   (req_rs2_i),
        .fwd_valid_i (res_valid_o),
        .fwd_rd_i    (res_rd_o),
        .fwd_data_i  (res_data_o),
        .acc_ready_i (acc_ready),
        .req_ready_o (req_ready_o),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req)
    );

    ls_access u_ls_access (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_valid_i (dec_valid),
        .dec_req_i   (dec_req),
        .wb_s_i      (wb_s),
        .acc_ready_o (acc_ready),
        .wb_m_o      (wb_m),
        .acc_o       (acc)
    );

    load_align u_load_align (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .acc_i       (acc),
        .res_valid_o (res_valid_o),
        .res_rd_o    (res_rd_o),
        .res_data_o  (res_data_o)
    );

    // 2 KiB data memory on the bus
    dmem_wb u_dmem_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_m_i  (wb_m),
        .wb_s_o  (wb_s)
    );

endmodule

`default_nettype wire

//--- hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // wishbone data and address widths
    localparam int WB_DW = 64;
    localparam int WB_AW = 64;
    // byte lanes per data word
    localparam int WB_SW = WB_DW / 8;
    // byte offset bits inside a data word
    localparam int WB_OB = $clog2(WB_SW);

    // data memory, 2 KiB of doublewords
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // master to slave, classic cycle
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_SW-1:0] sel;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_m2s_t;

    // slave to master, no err or rty
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // integer register width
    localparam int XLEN = 64;
    // register index width
    localparam int REG_AW = 5;
    // width of the loads-in-flight counter
    localparam int LDQ_CW = 3;

    // major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b000_0011;
    localparam logic [6:0] OPC_STORE = 7'b010_0011;

    // low two funct3 bits give log2 of the access size
    // bit 2 marks the unsigned loads
    // sb..sd reuse the signed load codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    // i-type view, used by loads
    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } instr_i_t;

    // s-type view, offset split around rs2/rs1
    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } instr_s_t;

    // one instruction word, two decodings
    typedef union packed {
        instr_i_t i_fmt;
        instr_s_t s_fmt;
    } instr_u;

    // decode stage output
    typedef struct packed {
        logic              is_load;
        logic              is_store;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
    } ls_req_t;

    // access stage output, raw doubleword plus where to cut it
    typedef struct packed {
        logic              valid;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [2:0]        off;
        logic [XLEN-1:0]   data;
    } ls_acc_t;

endpackage

`default_nettype wire

//--- sim/ls_vectors.hex
// instr rs1 rs2 flags rd expected_data, zero instr ends the list
// flags: high digit is the test group, bit 0 expects a result, bit 1 issues without a gap
01f10023 0000000000000100 1122334455667755 10 00 0000000000000000
01f11023 0000000000000108 0123456789ab1234 10 00 0000000000000000
01f12023 0000000000000110 0badcafe13572468 10 00 0000000000000000
01f13023 0000000000000118 fedcba9876543210 10 00 0000000000000000
00010083 0000000000000100 0000000000000000 11 01 0000000000000055
00011103 0000000000000108 0000000000000000 11 02 0000000000001234
00012183 0000000000000110 0000000000000000 11 03 0000000013572468
00013203 0000000000000118 0000000000000000 11 04 fedcba9876543210
01f10023 0000000000000205 77777777777777a5 20 00 0000000000000000
01f11023 000000000000020a 5555555555558001 20 00 0000000000000000
01f12023 0000000000000214 123456789abcdef0 20 00 0000000000000000
00010283 0000000000000205 0000000000000000 21 05 ffffffffffffffa5
00014303 0000000000000205 0000000000000000 21 06 00000000000000a5
00011383 000000000000020a 0000000000000000 21 07 ffffffffffff8001
00015403 000000000000020a 0000000000000000 21 08 0000000000008001
00012483 0000000000000214 0000000000000000 21 09 ffffffff9abcdef0
00016503 0000000000000214 0000000000000000 21 0a 000000009abcdef0
01f13023 0000000000000300 0011223344556677 30 00 0000000000000000
01f10023 0000000000000301 99999999999999aa 30 00 0000000000000000
01f10023 0000000000000306 88888888888888bb 30 00 0000000000000000
01f11023 0000000000000304 666666666666ccdd 30 00 0000000000000000
00013583 0000000000000300 0000000000000000 31 0b 00bbccdd4455aa77
00014603 0000000000000306 0000000000000000 31 0c 00000000000000bb
01f13023 0000000000000400 5a5a5a5ac3c3c3c3 40 00 0000000000000000
00013683 0000000000000400 0000000000000000 41 0d 5a5a5a5ac3c3c3c3
00d13023 0000000000000408 deaddeaddeaddead 42 00 0000000000000000
00013703 0000000000000408 0000000000000000 41 0e 5a5a5a5ac3c3c3c3
00012783 0000000000000110 0000000000000000 41 0f 0000000013572468
00f12023 0000000000000410 ffffffffffffffff 42 00 0000000000000000
00016803 0000000000000410 0000000000000000 41 10 0000000013572468
01f13023 0000000000000500 a1a2a3a4a5a6a7a8 50 00 0000000000000000
01f13023 0000000000000508 b1b2b3b4b5b6b7b8 50 00 0000000000000000
00013903 0000000000000500 0000000000000000 51 12 a1a2a3a4a5a6a7a8
00014983 000000000000050f 0000000000000000 51 13 00000000000000b1
01f12023 0000000000000504 000000000f0e0d0c 50 00 0000000000000000
00012a03 0000000000000504 0000000000000000 51 14 000000000f0e0d0c
00011a83 000000000000050c 0000000000000000 51 15 ffffffffffffb3b4
00013b03 0000000000000500 0000000000000000 51 16 0f0e0d0ca5a6a7a8
01f11023 000000000000050e 7777777777777e7f 50 00 0000000000000000
00013b83 0000000000000508 0000000000000000 51 17 7e7fb3b4b5b6b7b8
00015c03 0000000000000502 0000000000000000 51 18 000000000000a5a6
00013d03 0000000000000118 0000000000000000 53 1a fedcba9876543210
00013d83 0000000000000300 0000000000000000 53 1b 00bbccdd4455aa77
00000393 0000000000000000 0000000000000000 60 00 0000000000000000
00013003 0000000000000118 0000000000000000 61 00 fedcba9876543210
00013023 0000000000000418 0123012301230123 62 00 0000000000000000
00013883 0000000000000418 0000000000000000 61 11 0123012301230123
00000000 0000000000000000 0000000000000000 00 00 0000000000000000

//--- sim/tb_ls_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ls_top import rv_isa_pkg::*; ();

    localparam int MAX_REC   = 64;
    // words per record: instr, rs1, rs2, flags, rd, data
    localparam int REC_W     = 6;
    localparam int READY_TMO = 64;
    localparam int DRAIN_TMO = 256;
    localparam logic [31:0] SEED = 32'hd3c2_5efd;

    // one outstanding load result
    typedef struct packed {
        logic [3:0]        group;
        logic [7:0]        idx;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    instr_u            req_instr;
    logic [XLEN-1:0]   req_rs1;
    logic [XLEN-1:0]   req_rs2;
    logic              req_ready;
    logic              res_valid;
    logic [REG_AW-1:0] res_rd;
    logic [XLEN-1:0]   res_data;

    logic [63:0] vec_mem [MAX_REC*REC_W];
    // expected results in issue order
    expect_t     exp_q [$];
    int          check_errs;
    int          timeout_errs;

    ls_top dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_instr_i (req_instr),
        .req_rs1_i   (req_rs1),
        .req_rs2_i   (req_rs2),
        .req_ready_o (req_ready),
        .res_valid_o (res_valid),
        .res_rd_o    (res_rd),
        .res_data_o  (res_data)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // group number from the vector file to a readable name
    function automatic string test_name(input logic [3:0] group);
        case (group)
            4'd1:    return "store_load_sizes";
            4'd2:    return "sign_zero_extend";
            4'd3:    return "byte_lane_merge";
            4'd4:    return "load_store_forward";
            4'd5:    return "mixed_stream_order";
            4'd6:    return "non_mem_and_x0";
            default: return "unknown";
        endcase
    endfunction

    // drive one record, enter and leave on a falling edge
    task automatic issue_request(input int rec, output bit timed_out);
        int      base;
        logic [7:0] flags;
        int      gap;
        int      waited;
        expect_t exp;
        base      = rec * REC_W;
        flags     = vec_mem[base+3][7:0];
        timed_out = 1'b0;
        // bit 1 asks for back-to-back issue
        if (!flags[1]) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
        end
        req_valid = 1'b1;
        req_instr = vec_mem[base][31:0];
        req_rs1   = vec_mem[base+1];
        req_rs2   = vec_mem[base+2];
        // ready only moves on rising edges
        waited = 0;
        while (!req_ready && waited < READY_TMO) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("timeout: record %0d was not accepted within %0d cycles", rec, READY_TMO);
            timeout_errs++;
            timed_out = 1'b1;
            req_valid = 1'b0;
        end else begin
            // transfer on the coming rising edge
            if (flags[0]) begin
                exp.group = flags[7:4];
                exp.idx   = 8'(rec);
                exp.rd    = vec_mem[base+4][REG_AW-1:0];
                exp.data  = vec_mem[base+5];
                exp_q.push_back(exp);
            end
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // result checker, samples mid-cycle
    always @(negedge clk) begin : check_results
        expect_t exp;
        if (rst_n && res_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("result for x%0d arrived with no load outstanding", res_rd);
                check_errs++;
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                assert (res_rd == exp.rd) else begin
                    $display("CHECK FAILED %s record %0d rd: expected x%0d actual x%0d",
                             test_name(exp.group), exp.idx, exp.rd, res_rd);
                    check_errs++;
                end
                assert (res_data == exp.data) else begin
                    $display("CHECK FAILED %s record %0d data: expected %h actual %h",
                             test_name(exp.group), exp.idx, exp.data, res_data);
                    check_errs++;
                end
            end
        end
    end

    initial begin : run
        int rec;
        int waited;
        bit timed_out;
        check_errs   = 0;
        timeout_errs = 0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_instr    = '0;
        req_rs1      = '0;
        req_rs2      = '0;
        void'($urandom(SEED));
        // a zero instruction word ends the list
        for (int i = 0; i < MAX_REC*REC_W; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("sim/ls_vectors.hex", vec_mem);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        rec       = 0;
        timed_out = 1'b0;
        while (!timed_out && rec < MAX_REC && vec_mem[rec*REC_W] != '0) begin
            issue_request(rec, timed_out);
            rec++;
        end
        // drain outstanding loads
        waited = 0;
        while (!timed_out && exp_q.size() > 0 && waited < DRAIN_TMO) begin
            @(negedge clk);
            waited++;
        end
        if (!timed_out && exp_q.size() > 0) begin
            $display("timeout: %0d load results never arrived", exp_q.size());
            timeout_errs++;
        end
        // quiet tail, a stray pulse still gets caught
        repeat (8) @(negedge clk);
        $display("errors: %0d failed checks, %0d timeouts", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/rv_isa_pkg.sv
hw/mem_bus_pkg.sv
hw/ls_decode.sv
hw/ls_access.sv
hw/load_align.sv
hw/dmem_wb.sv
hw/ls_top.sv
sim/tb_ls_top.sv
